//--- verilog/cart_settings.svh
/*
	Cartridge mapper constants
	SDRAM address width, bank index width, page table depth,
	ROM and RAM page prefixes and the Ocean Type B threshold
*/

`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ********************
// Widths
// ********************

`define CART_ADDR_W 25 // SDRAM byte address
`define CART_BANK_W 7 // Up to 128 banks of 8k

// ********************
// Page table and SDRAM layout
// ********************

`define CART_TABLE_DEPTH 64 // Entries per table, low and high

// ROM banks start at 1 MB, RAM banks at 64 KB
`define CART_ROM_PREFIX 1'b1
`define CART_RAM_PREFIX 5'b00001

`define CART_OCEAN_B_BANK 32 // First bank that only a 512k Ocean image has

`endif

//--- verilog/cart_pkg.sv
/*
	Shared cartridge mapper types
	Cartridge type IDs, bank index, CRT chip packet,
	CPU bus cycle and mapping state
*/

`default_nettype none

`include "cart_settings.svh"

package cart_pkg;

	// CRT header hardware type, only the kept mappers
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,
		CART_OCEAN      = 16'd5,
		CART_DINAMIC    = 16'd17,
		CART_MAGIC_DESK = 16'd19,
		CART_EASYFLASH  = 16'd32
	} cart_type_e;

	typedef logic [`CART_BANK_W-1:0] bank_t;

	// One CHIP packet as the loader sees it
	typedef struct packed {
		logic [15:0]             bank_num;
		logic [15:0]             bank_size; // Bytes
		logic [`CART_ADDR_W-1:0] sdram_addr; // Where the packet data landed
		logic                    wr;
	} bank_load_t;

	// CPU side of one expansion port cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;
		logic        mem_ce;
		logic        roml; // $8000-$9FFF
		logic        romh; // $A000-$BFFF or $E000-$FFFF
		logic        ioe; // $DExx
		logic        iof; // $DFxx
	} cpu_bus_t;

	// Mapping state, driven by the controller
	typedef struct packed {
		bank_t bank_lo;
		bank_t bank_hi;
		bank_t iof_bank;
		logic  exrom;
		logic  game;
		logic  ioe_ena; // ROM visible at DExx
		logic  iof_ena;
		logic  iof_wr_ena; // DFxx is RAM
		logic  roml_we;
	} cart_map_t;

endpackage

`default_nettype wire

//--- verilog/bank_table.sv
/*
	Per-bank SDRAM page table
	Low and high tables filled from CRT chip packets,
	loaded bank count and Ocean Type B detection
*/

`default_nettype none

`include "cart_settings.svh"

module bank_table import cart_pkg::*; (
	input  logic       clk32,
	input  logic       cart_loading,
	input  bank_load_t bank_load,
	input  bank_t      sel,
	output bank_t      entry0_lo,
	output bank_t      entry0_hi,
	output bank_t      sel_lo,
	output bank_t      sel_hi,
	output logic [7:0] bank_cnt,
	output logic       ocean_b_seen
);

	localparam int IDX_W = $clog2(`CART_TABLE_DEPTH);

	bank_t lo_tab [`CART_TABLE_DEPTH];
	bank_t hi_tab [`CART_TABLE_DEPTH];

	logic       old_loading;
	logic       load_start;
	logic       in_table;
	logic [IDX_W-1:0] wr_idx;
	bank_t      page;

	assign load_start = cart_loading & ~old_loading;
	assign in_table   = bank_load.bank_num < 16'(`CART_TABLE_DEPTH);
	assign wr_idx     = bank_load.bank_num[IDX_W-1:0];
	assign page       = bank_load.sdram_addr[19:13]; // 8k page inside the image

	// ********************
	// Table fill
	// ********************

	always_ff @(posedge clk32) begin
		if (bank_load.wr && in_table) begin
			lo_tab[wr_idx] <= page;
			// A 16k chip also covers the next 8k page
			if (bank_load.bank_size > 16'h2000)
				hi_tab[wr_idx] <= page + 1'b1;
		end
	end

	// Bank count and size detection restart with each new load
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (load_start) begin
			bank_cnt     <= '0;
			ocean_b_seen <= 1'b0;
		end else if (bank_load.wr) begin
			bank_cnt <= bank_cnt + 1'b1;
			if (bank_load.bank_num >= 16'(`CART_OCEAN_B_BANK))
				ocean_b_seen <= 1'b1;
		end
	end

	// ********************
	// Lookups
	// ********************

	assign entry0_lo = lo_tab[0];
	assign entry0_hi = hi_tab[0];

	// Bank numbers past the table read as page 0
	assign sel_lo = (sel < bank_t'(`CART_TABLE_DEPTH)) ? lo_tab[sel[IDX_W-1:0]] : '0;
	assign sel_hi = (sel < bank_t'(`CART_TABLE_DEPTH)) ? hi_tab[sel[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

//--- verilog/cart_control.sv
/*
	Cartridge register logic
	IOE/IOF edge strobes, init defaults and the per-type
	bank, EXROM/GAME and IO enable behavior
*/

`default_nettype none

module cart_control import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  cart_type_e cart_id,
	input  logic       cart_exrom,
	input  logic       cart_game,
	input  cpu_bus_t   bus,
	input  bank_t      entry0_lo,
	input  bank_t      entry0_hi,
	input  bank_t      sel_lo,
	input  bank_t      sel_hi,
	input  logic [7:0] bank_cnt,
	input  logic       ocean_b_seen,
	output bank_t      sel,
	output cart_map_t  map,
	output logic       io_strobe_e,
	output logic       io_strobe_f
);

	cart_type_e old_id;
	logic       init_done; // Low for the first cycle after reset
	logic       old_ioe;
	logic       old_iof;
	logic       ioe_wr;
	logic       ioe_rd;
	logic       ctl_reset;
	bank_t      md_bank;

	// ********************
	// IO strobes
	// ********************

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
		end else begin
			old_ioe <= bus.ioe;
			old_iof <= bus.iof;
		end
	end

	// Only the first cycle of a select pulse counts
	assign io_strobe_e = bus.ioe & ~old_ioe;
	assign io_strobe_f = bus.iof & ~old_iof;

	assign ioe_wr = io_strobe_e & bus.write;
	assign ioe_rd = io_strobe_e & ~bus.write;

	// EasyFlash bank register indexes the page table
	assign sel = bank_t'(bus.data[5:0]);

	// Magic Desk ignores data bits the image has no banks for
	always_comb begin
		if (bank_cnt <= 8'd16)
			md_bank = bank_t'(bus.data[3:0]);
		else if (bank_cnt <= 8'd32)
			md_bank = bank_t'(bus.data[4:0]);
		else if (bank_cnt <= 8'd64)
			md_bank = bank_t'(bus.data[5:0]);
		else
			md_bank = bus.data[6:0];
	end

	// A new cartridge type restarts the mapper like a reset
	assign ctl_reset = reset_n | (cart_id != old_id);

	// ********************
	// Per-type registers
	// ********************

	always_ff @(posedge clk32) begin
		old_id    <= cart_id;
		init_done <= 1'b1;

		if (ctl_reset) begin
			init_done <= 1'b0;
			map       <= '0;
			map.exrom <= 1'b1; // Cartridge invisible
			map.game  <= 1'b1;
		end else begin
			case (cart_id)
				// 8k, 16k or Ultimax straight from the CRT header
				CART_GENERIC: begin
					map.exrom   <= cart_exrom;
					map.game    <= cart_game;
					map.bank_lo <= entry0_lo;
					map.bank_hi <= entry0_hi;
				end

				// Bank at $DE00, same bank mirrored at $8000 and $A000
				CART_OCEAN: begin
					if (!init_done) begin
						map.exrom <= 1'b0;
						map.game  <= 1'b0;
					end
					if (ioe_wr) begin
						map.bank_lo <= bank_t'(bus.data[5:0]);
						map.bank_hi <= bank_t'(bus.data[5:0]);
					end
					if (ocean_b_seen)
						map.game <= 1'b1; // 512k image uses $8000 only
				end

				CART_MAGIC_DESK: begin
					if (!init_done) begin
						map.exrom   <= 1'b0;
						map.game    <= 1'b1;
						map.bank_lo <= '0;
					end
					if (ioe_wr) begin
						map.bank_lo <= md_bank;
						map.exrom   <= bus.data[7]; // Bit 7 hides the cartridge
					end
				end

				// Reading $DE0x selects bank x
				CART_DINAMIC: begin
					map.exrom <= 1'b0;
					map.game  <= 1'b1;
					if (ioe_rd)
						map.bank_lo <= bank_t'(bus.addr[3:0]);
				end

				CART_EASYFLASH: begin
					if (!init_done) begin
						map.iof_bank   <= '0;
						map.iof_ena    <= 1'b1;
						map.iof_wr_ena <= 1'b1; // 256 bytes of RAM at $DFxx
						map.exrom      <= 1'b1; // Boots in Ultimax
						map.game       <= 1'b0;
						map.bank_lo    <= entry0_lo;
						map.bank_hi    <= entry0_hi;
					end
					if (ioe_wr) begin
						if (bus.addr[1]) begin
							// $DE02 control, boot jumper read as bit 2
							map.game  <= ~bus.data[0] & bus.data[2];
							map.exrom <= ~bus.data[1];
						end else begin
							map.bank_lo <= sel_lo; // $DE00 bank
							map.bank_hi <= sel_hi;
						end
					end
				end

				default: begin
					map.exrom <= 1'b1;
					map.game  <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/addr_translate.sv
/*
	SDRAM address translation
	ROM and RAM page mapping, IO relocation,
	Ultimax write block and chip enable
*/

`default_nettype none

`include "cart_settings.svh"

module addr_translate import cart_pkg::*; (
	input  logic                    reset_n,
	input  cpu_bus_t                bus,
	input  cart_map_t               map,
	input  logic                    io_strobe_e,
	input  logic                    io_strobe_f,
	output logic [`CART_ADDR_W-1:0] addr_out,
	output logic                    mem_write_out,
	output logic                    mem_ce_out
);

	localparam int PAGE_W = `CART_ADDR_W - 13; // Bits above the 8k offset

	logic cs_ioe;
	logic cs_iof;
	logic ultimax_blk;

	// RAM pages sit at 64 KB, ROM pages at 1 MB
	function automatic logic [PAGE_W-1:0] get_page(input bank_t bank, input logic ram);
		logic [PAGE_W-1:0] page;
		if (ram)
			page = PAGE_W'({`CART_RAM_PREFIX, bank[2:0]});
		else
			page = PAGE_W'({`CART_ROM_PREFIX, bank});
		return page;
	endfunction

	// ********************
	// IO selects
	// ********************

	assign cs_ioe = bus.ioe & ~bus.write & map.ioe_ena;
	assign cs_iof = bus.iof & (bus.write ? map.iof_wr_ena : map.iof_ena);

	// Extra SDRAM cycle for DExx/DFxx, first cycle only
	assign mem_ce_out = bus.mem_ce | (cs_ioe & io_strobe_e) | (cs_iof & io_strobe_f);

	// Ultimax has no RAM under ROML
	assign ultimax_blk   = bus.roml & ~map.roml_we & map.exrom & ~map.game;
	assign mem_write_out = bus.write & ~ultimax_blk;

	// ********************
	// Address
	// ********************

	always_comb begin
		addr_out = `CART_ADDR_W'(bus.addr);

		if (!reset_n) begin // reset_n is high while in reset
			if (bus.romh && !bus.write)
				addr_out[`CART_ADDR_W-1:13] = get_page(map.bank_hi, 1'b0);
			if (bus.roml && (map.roml_we || !bus.write))
				addr_out[`CART_ADDR_W-1:13] = get_page(map.bank_lo, map.roml_we);

			if (cs_ioe)
				addr_out[`CART_ADDR_W-1:13] = get_page(map.bank_lo, 1'b0); // DExx shows ROML bank
			if (cs_iof)
				addr_out[`CART_ADDR_W-1:13] = get_page(map.iof_bank, map.iof_wr_ena);
		end
	end

endmodule

`default_nettype wire

//--- verilog/cartridge.sv
/*
	C64 cartridge mapper top level
	Page table, register logic and address translation
*/

`default_nettype none

`include "cart_settings.svh"

module cartridge import cart_pkg::*; (
	input  logic                    clk32,
	input  logic                    reset_n,
	input  cart_type_e              cart_id,
	input  logic                    cart_exrom, // CRT header EXROM
	input  logic                    cart_game, // CRT header GAME
	input  logic                    cart_loading,
	input  bank_load_t              bank_load,
	input  cpu_bus_t                bus,
	output logic                    exrom,
	output logic                    game,
	output logic [`CART_ADDR_W-1:0] addr_out,
	output logic                    mem_write_out,
	output logic                    mem_ce_out
);

	bank_t      sel;
	bank_t      entry0_lo;
	bank_t      entry0_hi;
	bank_t      sel_lo;
	bank_t      sel_hi;
	logic [7:0] bank_cnt;
	logic       ocean_b_seen;
	cart_map_t  map;
	logic       io_strobe_e;
	logic       io_strobe_f;

	bank_table u_bank_table (
		.clk32        (clk32),
		.cart_loading (cart_loading),
		.bank_load    (bank_load),
		.sel          (sel),
		.entry0_lo    (entry0_lo),
		.entry0_hi    (entry0_hi),
		.sel_lo       (sel_lo),
		.sel_hi       (sel_hi),
		.bank_cnt     (bank_cnt),
		.ocean_b_seen (ocean_b_seen)
	);

	cart_control u_cart_control (
		.clk32        (clk32),
		.reset_n      (reset_n),
		.cart_id      (cart_id),
		.cart_exrom   (cart_exrom),
		.cart_game    (cart_game),
		.bus          (bus),
		.entry0_lo    (entry0_lo),
		.entry0_hi    (entry0_hi),
		.sel_lo       (sel_lo),
		.sel_hi       (sel_hi),
		.bank_cnt     (bank_cnt),
		.ocean_b_seen (ocean_b_seen),
		.sel          (sel),
		.map          (map),
		.io_strobe_e  (io_strobe_e),
		.io_strobe_f  (io_strobe_f)
	);

	addr_translate u_addr_translate (
		.reset_n       (reset_n),
		.bus           (bus),
		.map           (map),
		.io_strobe_e   (io_strobe_e),
		.io_strobe_f   (io_strobe_f),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.mem_ce_out    (mem_ce_out)
	);

	// Expansion port lines
	assign exrom = map.exrom;
	assign game  = map.game;

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
/*
	Testbench clock and reset
	4 ns clk32, reset held for two cycles
*/

`default_nettype none

module clock_gen (
	output logic clk32,
	output logic reset_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk32 = 1'b0;
		forever #2 clk32 = ~clk32;
	end

	initial begin
		reset_n = 1'b1; // In reset while high
		repeat (2) @(posedge clk32);
		#1 reset_n = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/cart_props.sv
/*
	Concurrent checks on the mapper ports
	Reset state, chip enable, IO strobe width,
	Ultimax write block and ROM page placement
*/

`default_nettype none

`include "cart_settings.svh"

module cart_props import cart_pkg::*; (
	input logic                    clk32,
	input logic                    reset_n,
	input cpu_bus_t                bus,
	input cart_map_t               map,
	input logic                    exrom,
	input logic                    game,
	input logic [`CART_ADDR_W-1:0] addr_out,
	input logic                    mem_write_out,
	input logic                    mem_ce_out
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0; // Summed up by the testbench

	// Reset hides the cartridge
	a_reset_lines: assert property (@(posedge clk32) reset_n |=> exrom && game)
	else begin
		fail_cnt++;
		$error("EXROM/GAME not both 1 after a reset cycle");
	end

	// First cycle of an enabled IOF select gets an SDRAM cycle
	a_iof_first: assert property (@(posedge clk32) disable iff (reset_n)
		(bus.iof && !$past(bus.iof) && $past(!reset_n)
			&& (bus.write ? map.iof_wr_ena : map.iof_ena)) |-> mem_ce_out)
	else begin
		fail_cnt++;
		$error("mem_ce_out low in the first cycle of an enabled IOF select");
	end

	// A held IOF select gets one SDRAM cycle only
	a_iof_once: assert property (@(posedge clk32) disable iff (reset_n)
		(bus.iof && !bus.ioe && !bus.mem_ce && $past(bus.iof) && $past(!reset_n))
		|-> !mem_ce_out)
	else begin
		fail_cnt++;
		$error("mem_ce_out high past the first IOF cycle");
	end

	// ********************
	// Translation
	// ********************

	a_ultimax_wr: assert property (@(posedge clk32) disable iff (reset_n)
		(bus.roml && bus.write && exrom && !game && !map.roml_we) |-> !mem_write_out)
	else begin
		fail_cnt++;
		$error("ROML write reached SDRAM in Ultimax");
	end

	a_rom_page: assert property (@(posedge clk32) disable iff (reset_n)
		(bus.roml && !bus.write && !bus.ioe && !bus.iof && !map.roml_we)
		|-> addr_out[24:20] == 5'b00001) // ROM image at 1 MB
	else begin
		fail_cnt++;
		$error("ROML read outside the ROM area");
	end

endmodule

bind cartridge cart_props u_props (
	.clk32         (clk32),
	.reset_n       (reset_n),
	.bus           (bus),
	.map           (map),
	.exrom         (exrom),
	.game          (game),
	.addr_out      (addr_out),
	.mem_write_out (mem_write_out),
	.mem_ce_out    (mem_ce_out)
);

`default_nettype wire

//--- tests/cart_tb.sv
/*
	Cartridge mapper testbench
	Reset and init, generic, Ocean, Magic Desk and EasyFlash
	stimulus, value checks and the closing summary
*/

`default_nettype none

`include "cart_settings.svh"

module cart_tb import cart_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 50; // Cycles per wait

	logic                    clk32;
	logic                    reset_n;
	cart_type_e              cart_id;
	logic                    cart_exrom;
	logic                    cart_game;
	logic                    cart_loading;
	bank_load_t              bank_load;
	cpu_bus_t                bus;
	logic                    exrom;
	logic                    game;
	logic [`CART_ADDR_W-1:0] addr_out;
	logic                    mem_write_out;
	logic                    mem_ce_out;

	int         value_errs;
	int         timeouts;
	bank_t      page;
	logic [7:0] d;

	clock_gen u_clock_gen (
		.clk32   (clk32),
		.reset_n (reset_n)
	);

	cartridge i_dut (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.cart_id       (cart_id),
		.cart_exrom    (cart_exrom),
		.cart_game     (cart_game),
		.cart_loading  (cart_loading),
		.bank_load     (bank_load),
		.bus           (bus),
		.exrom         (exrom),
		.game          (game),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.mem_ce_out    (mem_ce_out)
	);

	// ********************
	// Helpers
	// ********************

	task automatic next_cycle();
		@(posedge clk32);
		#1; // Drive point
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Reset is looked at on the clock edge
	task automatic wait_reset_done();
		int n;
		n = 0;
		@(posedge clk32);
		while (reset_n !== 1'b0 && n < TIMEOUT) begin
			@(posedge clk32);
			n++;
		end
		#1; // Drive point
		if (reset_n !== 1'b0) begin
			timeouts++;
			$display("Timeout: reset was never released (%0t ns)", $time);
		end
	endtask

	task automatic wait_lines(input logic exp_exrom, input logic exp_game);
		int n;
		n = 0;
		while ((exrom !== exp_exrom || game !== exp_game) && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (exrom !== exp_exrom || game !== exp_game) begin
			timeouts++;
			$display("Timeout: EXROM/GAME never became %b/%b (%0t ns)",
				exp_exrom, exp_game, $time);
		end
	endtask

	// Type change costs a restart cycle and an init cycle
	task automatic select_type(input cart_type_e id);
		cart_id = id;
		next_cycle();
		next_cycle();
	endtask

	task automatic start_load();
		cart_loading = 1'b1;
		next_cycle(); // Rising edge clears the bank count
	endtask

	task automatic load_packet(input int num, input int size, input logic [24:0] addr);
		bank_load.bank_num   = 16'(num);
		bank_load.bank_size  = 16'(size);
		bank_load.sdram_addr = addr;
		bank_load.wr         = 1'b1;
		next_cycle();
		bank_load = '0;
	endtask

	// Selects follow from the C64 memory map
	task automatic access(input logic [15:0] addr, input logic [7:0] data, input logic wr);
		bus        = '0;
		bus.addr   = addr;
		bus.data   = data;
		bus.write  = wr;
		bus.roml   = addr[15:13] == 3'b100;
		bus.romh   = addr[15:13] == 3'b101 || addr[15:13] == 3'b111;
		bus.ioe    = addr[15:8] == 8'hDE;
		bus.iof    = addr[15:8] == 8'hDF;
		bus.mem_ce = bus.roml | bus.romh;
		#1; // Let the translation settle
	endtask

	// ROM image at 1 MB, RAM at 64 KB, both in 8k pages
	function automatic logic [31:0] rom_addr(input bank_t bank, input logic [15:0] addr);
		return 32'h10_0000 | 32'({bank, addr[12:0]});
	endfunction

	function automatic logic [31:0] ram_addr(input bank_t bank, input logic [15:0] addr);
		return 32'h1_0000 | 32'({bank[2:0], addr[12:0]});
	endfunction

	// ********************
	// Stimulus
	// ********************

	initial begin
		void'($urandom(89));
		value_errs   = 0;
		timeouts     = 0;
		cart_id      = CART_GENERIC;
		cart_exrom   = 1'b0;
		cart_game    = 1'b1;
		cart_loading = 1'b0;
		bank_load    = '0;
		bus          = '0;

		// Reset, then generic header lines
		next_cycle();
		access(16'hDF00, 8'h00, 1'b1); // IO RAM must stay off in reset
		check_value("exrom in reset", 32'(exrom), 32'd1);
		check_value("game in reset", 32'(game), 32'd1);
		check_value("mem_ce_out in reset", 32'(mem_ce_out), 32'(bus.mem_ce));
		bus = '0;
		wait_reset_done();
		wait_lines(1'b0, 1'b1);

		// Generic 16k image
		page = bank_t'($urandom);
		start_load();
		load_packet(0, 16'h4000, 25'({page, 13'h0}));
		cart_loading = 1'b0;
		next_cycle();
		access(16'h8123, 8'h00, 1'b0);
		check_value("generic ROML addr", 32'(addr_out), rom_addr(page, 16'h8123));
		next_cycle();
		access(16'hA456, 8'h00, 1'b0);
		check_value("generic ROMH addr", 32'(addr_out), rom_addr(bank_t'(page + 7'd1), 16'hA456));

		// Ocean, then a 512k image
		next_cycle();
		bus = '0;
		select_type(CART_OCEAN);
		wait_lines(1'b0, 1'b0);
		d = 8'($urandom);
		access(16'hDE00, d, 1'b1);
		next_cycle();
		access(16'h8ABC, 8'h00, 1'b0);
		check_value("ocean ROML addr", 32'(addr_out), rom_addr(bank_t'(d[5:0]), 16'h8ABC));
		next_cycle();
		access(16'hBFFF, 8'h00, 1'b0);
		check_value("ocean ROMH addr", 32'(addr_out), rom_addr(bank_t'(d[5:0]), 16'hBFFF));
		next_cycle();
		bus = '0;
		start_load();
		load_packet(32, 16'h2000, 25'h04_0000);
		cart_loading = 1'b0;
		wait_lines(1'b0, 1'b1);

		// Magic Desk with 16 banks
		start_load();
		for (int i = 0; i < 16; i++)
			load_packet(i, 16'h2000, 25'(i) << 13);
		cart_loading = 1'b0;
		select_type(CART_MAGIC_DESK);
		wait_lines(1'b0, 1'b1);
		d = 8'($urandom) | 8'hF0; // Bits 6:4 must be masked off
		access(16'hDE00, d, 1'b1);
		next_cycle();
		access(16'h9000, 8'h00, 1'b0);
		check_value("magic desk exrom", 32'(exrom), 32'd1);
		check_value("magic desk ROML addr", 32'(addr_out), rom_addr(bank_t'(d[3:0]), 16'h9000));

		// EasyFlash boots in Ultimax
		next_cycle();
		bus = '0;
		select_type(CART_EASYFLASH);
		wait_lines(1'b1, 1'b0);
		access(16'h8000, 8'h55, 1'b1);
		check_value("Ultimax ROML write", 32'(mem_write_out), 32'd0);
		next_cycle();
		d = 8'($urandom);
		access(16'hDE02, d, 1'b1);
		next_cycle();
		bus = '0;
		#1;
		check_value("easyflash exrom", 32'(exrom), {31'd0, ~d[1]});
		check_value("easyflash game", 32'(game), {31'd0, ~d[0] & d[2]});
		access(16'hDF37, 8'hA5, 1'b1);
		check_value("easyflash RAM addr", 32'(addr_out), ram_addr('0, 16'hDF37));
		check_value("easyflash RAM write", 32'(mem_write_out), 32'd1);
		check_value("IOF first cycle ce", 32'(mem_ce_out), 32'd1);
		next_cycle(); // Select still held
		check_value("IOF second cycle ce", 32'(mem_ce_out), 32'd0);

		next_cycle();
		bus = '0;
		next_cycle();
		next_cycle();
		$display("value errors %0d, assertion failures %0d, timeouts %0d",
			value_errs, i_dut.u_props.fail_cnt, timeouts);
		if (value_errs + i_dut.u_props.fail_cnt + timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/bank_table.sv
verilog/cart_control.sv
verilog/addr_translate.sv
verilog/cartridge.sv
tests/clock_gen.sv
tests/cart_props.sv
tests/cart_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cart_tb
FILELIST  = list.f
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = NO ERRORS

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
